//--- include/iq_params.svh
`ifndef IQ_PARAMS_SVH
`define IQ_PARAMS_SVH

// entries per thread queue
`define IQ_DEPTH 16

// lanes on each side
`define IQ_WRITE_LANES 4
`define IQ_READ_LANES 3

// payload widths
`define IQ_INSTR_W 32
`define IQ_OTHER_W 8

// writes refused once a thread holds more than this
// (depth minus write lanes, so a full-width write always fits)
`define IQ_STALL_LEVEL 12

`endif

//--- design/iq_pkg.sv
`include "iq_params.svh"

package iq_pkg;

  typedef logic [`IQ_INSTR_W-1:0] instr_t;
  typedef logic [`IQ_OTHER_W-1:0] other_t;

  // wraps around the circular queue
  typedef logic [$clog2(`IQ_DEPTH)-1:0] ptr_t;
  typedef logic [$clog2(`IQ_DEPTH+1)-1:0] count_t;

  typedef logic [`IQ_WRITE_LANES-1:0] wlanes_t;
  typedef logic [`IQ_READ_LANES-1:0] rlanes_t;
  typedef logic [$clog2(`IQ_WRITE_LANES+1)-1:0] lane_cnt_t;

  // popcount of a lane mask
  // read masks come in zero extended
  function automatic lane_cnt_t lane_count(input wlanes_t mask);
    lane_cnt_t n;
    n = '0;
    for (int i = 0; i < `IQ_WRITE_LANES; i++) begin
      n = n + lane_cnt_t'(mask[i]);
    end
    return n;
  endfunction

endpackage

//--- design/iq_write_ctrl.sv
`timescale 1ns/100ps
`include "iq_params.svh"

module iq_write_ctrl
  import iq_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      write_wen,
  input  logic      write_thread,
  input  wlanes_t   write_instr_en,
  input  logic      stall,
  input  logic      except,
  input  logic      except_thread,
  output logic      wr_en,
  output logic      wr_thread,
  output ptr_t      wr_base,
  output wlanes_t   wr_lanes,
  output lane_cnt_t wr_count
);

  ptr_t      wr_ptr [2];
  lane_cnt_t lane_cnt;
  logic      flush_hit;

  assign lane_cnt = lane_count(write_instr_en);

  // flush of the written thread wins over the write
  assign flush_hit = except && (except_thread == write_thread);

  assign wr_en     = write_wen && !stall && !flush_hit;
  assign wr_thread = write_thread;
  assign wr_base   = wr_ptr[write_thread];
  assign wr_lanes  = write_instr_en;
  assign wr_count  = wr_en ? lane_cnt : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr[0] <= '0;
      wr_ptr[1] <= '0;
    end else begin
      for (int t = 0; t < 2; t++) begin
        if (except && (except_thread == 1'(t))) begin
          wr_ptr[t] <= '0;
        end else if (wr_en && (write_thread == 1'(t))) begin
          wr_ptr[t] <= wr_ptr[t] + ptr_t'(lane_cnt);
        end
      end
    end
  end

endmodule

//--- design/iq_storage.sv
`timescale 1ns/100ps
`include "iq_params.svh"

module iq_storage
  import iq_pkg::*;
(
  input  logic                             clk,
  input  logic                             wr_en,
  input  logic                             wr_thread,
  input  ptr_t                             wr_base,
  input  wlanes_t                          wr_lanes,
  input  instr_t [`IQ_WRITE_LANES-1:0]     write_instr,
  input  other_t [`IQ_WRITE_LANES-1:0]     write_other,
  input  logic                             rd_thread,
  input  ptr_t                             rd_head,
  output instr_t [`IQ_READ_LANES-1:0]      read_instr,
  output other_t [`IQ_READ_LANES-1:0]      read_other
);

  instr_t instr_mem [2][`IQ_DEPTH];
  other_t other_mem [2][`IQ_DEPTH];

  ptr_t wr_addr [`IQ_WRITE_LANES];
  ptr_t rd_addr [`IQ_READ_LANES];

  // lane k lands k entries past the write pointer
  always_comb begin
    for (int w = 0; w < `IQ_WRITE_LANES; w++) begin
      wr_addr[w] = wr_base + ptr_t'(w);
    end
  end

  always_comb begin
    for (int r = 0; r < `IQ_READ_LANES; r++) begin
      rd_addr[r] = rd_head + ptr_t'(r);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int w = 0; w < `IQ_WRITE_LANES; w++) begin
        if (wr_lanes[w]) begin
          instr_mem[wr_thread][wr_addr[w]] <= write_instr[w];
          other_mem[wr_thread][wr_addr[w]] <= write_other[w];
        end
      end
    end
  end

  // lanes past the occupancy show stale data
  always_comb begin
    for (int r = 0; r < `IQ_READ_LANES; r++) begin
      read_instr[r] = instr_mem[rd_thread][rd_addr[r]];
      read_other[r] = other_mem[rd_thread][rd_addr[r]];
    end
  end

endmodule

//--- design/iq_occupancy.sv
`timescale 1ns/100ps
`include "iq_params.svh"

module iq_occupancy
  import iq_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      write_thread,
  input  lane_cnt_t wr_count,
  input  logic      rd_thread,
  input  lane_cnt_t rd_count,
  input  logic      except,
  input  logic      except_thread,
  output logic      stall,
  output rlanes_t   read_avail
);

  count_t count [2];
  count_t count_nxt [2];
  count_t add_cnt;
  count_t sub_cnt;

  // near full check on the thread being written
  assign stall = count[write_thread] > count_t'(`IQ_STALL_LEVEL);

  // lane r valid once more than r entries are queued
  always_comb begin
    for (int r = 0; r < `IQ_READ_LANES; r++) begin
      read_avail[r] = count[rd_thread] > count_t'(r);
    end
  end

  always_comb begin
    for (int t = 0; t < 2; t++) begin
      add_cnt = '0;
      sub_cnt = '0;
      if (write_thread == 1'(t)) begin
        add_cnt = count_t'(wr_count);
      end
      if (rd_thread == 1'(t)) begin
        sub_cnt = count_t'(rd_count);
      end
      count_nxt[t] = count[t] + add_cnt - sub_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count[0] <= '0;
      count[1] <= '0;
    end else begin
      for (int t = 0; t < 2; t++) begin
        if (except && (except_thread == 1'(t))) begin
          count[t] <= '0;
        end else begin
          count[t] <= count_nxt[t];
        end
      end
    end
  end

endmodule

//--- design/iq_read_ctrl.sv
`timescale 1ns/100ps
`include "iq_params.svh"

module iq_read_ctrl
  import iq_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      read_thread,
  input  logic      read_clk_en,
  input  rlanes_t   read_instr_en,
  input  logic      except,
  input  logic      except_thread,
  output logic      rd_thread,
  output ptr_t      rd_head,
  output lane_cnt_t rd_count
);

  ptr_t      rd_ptr [2];
  lane_cnt_t lane_cnt;
  logic      flush_hit;

  // read mask widened to the write mask width for the shared popcount
  assign lane_cnt = lane_count(wlanes_t'(read_instr_en));

  // no consumption from a thread being flushed
  assign flush_hit = except && (except_thread == rd_thread);

  assign rd_count = (read_clk_en && !flush_hit) ? lane_cnt : '0;
  assign rd_head  = rd_ptr[rd_thread];

  // thread select lags read_thread by one edge
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_thread <= 1'b0;
    end else begin
      rd_thread <= read_thread;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr[0] <= '0;
      rd_ptr[1] <= '0;
    end else begin
      for (int t = 0; t < 2; t++) begin
        if (except && (except_thread == 1'(t))) begin
          rd_ptr[t] <= '0;
        end else if (rd_thread == 1'(t)) begin
          rd_ptr[t] <= rd_ptr[t] + ptr_t'(rd_count);
        end
      end
    end
  end

endmodule

//--- design/iq_top.sv
`timescale 1ns/100ps
`include "iq_params.svh"

module iq_top
  import iq_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         write_wen,
  input  logic                         write_thread,
  input  wlanes_t                      write_instr_en,
  input  instr_t [`IQ_WRITE_LANES-1:0] write_instr,
  input  other_t [`IQ_WRITE_LANES-1:0] write_other,
  input  logic                         read_thread,
  input  logic                         read_clk_en,
  input  rlanes_t                      read_instr_en,
  input  logic                         except,
  input  logic                         except_thread,
  output logic                         stall,
  output rlanes_t                      read_avail,
  output instr_t [`IQ_READ_LANES-1:0]  read_instr,
  output other_t [`IQ_READ_LANES-1:0]  read_other
);

  // write side
  logic      wr_en;
  logic      wr_thread;
  ptr_t      wr_base;
  wlanes_t   wr_lanes;
  lane_cnt_t wr_count;

  // read side
  logic      rd_thread;
  ptr_t      rd_head;
  lane_cnt_t rd_count;

  iq_write_ctrl u_write_ctrl (
    .clk            (clk),
    .rst            (rst),
    .write_wen      (write_wen),
    .write_thread   (write_thread),
    .write_instr_en (write_instr_en),
    .stall          (stall),
    .except         (except),
    .except_thread  (except_thread),
    .wr_en          (wr_en),
    .wr_thread      (wr_thread),
    .wr_base        (wr_base),
    .wr_lanes       (wr_lanes),
    .wr_count       (wr_count)
  );

  iq_storage u_storage (
    .clk         (clk),
    .wr_en       (wr_en),
    .wr_thread   (wr_thread),
    .wr_base     (wr_base),
    .wr_lanes    (wr_lanes),
    .write_instr (write_instr),
    .write_other (write_other),
    .rd_thread   (rd_thread),
    .rd_head     (rd_head),
    .read_instr  (read_instr),
    .read_other  (read_other)
  );

  iq_occupancy u_occupancy (
    .clk           (clk),
    .rst           (rst),
    .write_thread  (write_thread),
    .wr_count      (wr_count),
    .rd_thread     (rd_thread),
    .rd_count      (rd_count),
    .except        (except),
    .except_thread (except_thread),
    .stall         (stall),
    .read_avail    (read_avail)
  );

  iq_read_ctrl u_read_ctrl (
    .clk           (clk),
    .rst           (rst),
    .read_thread   (read_thread),
    .read_clk_en   (read_clk_en),
    .read_instr_en (read_instr_en),
    .except        (except),
    .except_thread (except_thread),
    .rd_thread     (rd_thread),
    .rd_head       (rd_head),
    .rd_count      (rd_count)
  );

endmodule

//--- tests/iq_assertions.sv
`timescale 1ns/100ps
`include "iq_params.svh"

module iq_assertions
  import iq_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      write_wen,
  input logic      stall,
  input logic      except,
  input logic      except_thread,
  input logic      read_thread,
  input logic      wr_thread,
  input ptr_t      wr_base,
  input rlanes_t   read_avail
);

  int fail_count = 0;

  // refused write leaves the write pointer where it was
  refused_write_holds_ptr: assert property (@(posedge clk) disable iff (rst)
    (write_wen && stall && !except) |=>
      (wr_thread != $past(wr_thread)) || (wr_base == $past(wr_base)))
    else begin
      fail_count++;
      $error("write pointer moved on a refused write");
    end

  avail_contiguous: assert property (@(posedge clk) disable iff (rst)
    read_avail inside {3'b000, 3'b001, 3'b011, 3'b111})
    else begin
      fail_count++;
      $error("read_avail is not contiguous from lane 0");
    end

  stall_low_after_reset: assert property (@(posedge clk) rst |=> !stall)
    else begin
      fail_count++;
      $error("stall high in the cycle after reset");
    end

  // flushed thread reads back empty when it is the read thread
  flush_empties_thread: assert property (@(posedge clk) disable iff (rst)
    (except && (except_thread == read_thread)) |=> (read_avail == '0))
    else begin
      fail_count++;
      $error("flushed thread still shows entries");
    end

endmodule

bind iq_top iq_assertions assert0 (
  .clk           (clk),
  .rst           (rst),
  .write_wen     (write_wen),
  .stall         (stall),
  .except        (except),
  .except_thread (except_thread),
  .read_thread   (read_thread),
  .wr_thread     (wr_thread),
  .wr_base       (wr_base),
  .read_avail    (read_avail)
);

//--- tests/tb_iq_top.sv
`timescale 1ns/100ps
`include "iq_params.svh"

module tb_iq_top import iq_pkg::*; ();

  typedef logic [`IQ_INSTR_W+`IQ_OTHER_W-1:0] entry_t;

  // scripted run is about 500 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic                         clk;
  logic                         rst;
  logic                         write_wen;
  logic                         write_thread;
  wlanes_t                      write_instr_en;
  instr_t [`IQ_WRITE_LANES-1:0] write_instr;
  other_t [`IQ_WRITE_LANES-1:0] write_other;
  logic                         read_thread;
  logic                         read_clk_en;
  rlanes_t                      read_instr_en;
  logic                         except;
  logic                         except_thread;
  logic                         stall;
  rlanes_t                      read_avail;
  instr_t [`IQ_READ_LANES-1:0]  read_instr;
  other_t [`IQ_READ_LANES-1:0]  read_other;

  integer seed;
  int     errors = 0;
  int     timeouts = 0;
  int     cycle_count = 0;
  logic   stall_seen = 1'b0;

  // reference queues and the registered read thread
  entry_t mq [2][$];
  logic   rd_thread_m = 1'b0;

  iq_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .write_wen      (write_wen),
    .write_thread   (write_thread),
    .write_instr_en (write_instr_en),
    .write_instr    (write_instr),
    .write_other    (write_other),
    .read_thread    (read_thread),
    .read_clk_en    (read_clk_en),
    .read_instr_en  (read_instr_en),
    .except         (except),
    .except_thread  (except_thread),
    .stall          (stall),
    .read_avail     (read_avail),
    .read_instr     (read_instr),
    .read_other     (read_other)
  );

  always #20 clk = ~clk;

  function automatic int rand_below(input int limit);
    return {$random(seed)} % limit;
  endfunction

  // applies the inputs sampled at this edge
  task automatic model_update();
    int   nr;
    logic accept;
    nr = 0;
    if (rst) begin
      mq[0].delete();
      mq[1].delete();
      rd_thread_m = 1'b0;
    end else begin
      accept = write_wen && (mq[write_thread].size() <= `IQ_STALL_LEVEL) &&
               !(except && (except_thread == write_thread));
      if (read_clk_en && !(except && (except_thread == rd_thread_m))) begin
        for (int r = 0; r < `IQ_READ_LANES; r++) begin
          nr += read_instr_en[r];
        end
      end
      for (int i = 0; i < nr; i++) begin
        void'(mq[rd_thread_m].pop_front());
      end
      if (accept) begin
        for (int k = 0; k < `IQ_WRITE_LANES; k++) begin
          if (write_instr_en[k]) begin
            mq[write_thread].push_back({write_instr[k], write_other[k]});
          end
        end
      end
      if (except) begin
        mq[except_thread].delete();
      end
      rd_thread_m = read_thread;
    end
  endtask

  task automatic tick();
    @(posedge clk);
    model_update();
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    errors++;
    $display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
  endtask

  task automatic check_outputs();
    int      n;
    rlanes_t exp_avail;
    logic    exp_stall;
    entry_t  e;
    n = mq[rd_thread_m].size();
    for (int r = 0; r < `IQ_READ_LANES; r++) begin
      exp_avail[r] = (n > r);
    end
    exp_stall = (mq[write_thread].size() > `IQ_STALL_LEVEL);
    if (stall) begin
      stall_seen = 1'b1;
    end
    assert (read_avail === exp_avail) else report_mismatch("read_avail", exp_avail, read_avail);
    assert (stall === exp_stall) else report_mismatch("stall", exp_stall, stall);
    for (int r = 0; r < `IQ_READ_LANES && r < n; r++) begin
      e = mq[rd_thread_m][r];
      assert (read_instr[r] === e[`IQ_OTHER_W +: `IQ_INSTR_W])
        else report_mismatch($sformatf("read_instr[%0d]", r), e[`IQ_OTHER_W +: `IQ_INSTR_W],
                             read_instr[r]);
      assert (read_other[r] === e[`IQ_OTHER_W-1:0])
        else report_mismatch($sformatf("read_other[%0d]", r), e[`IQ_OTHER_W-1:0],
                             read_other[r]);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      check_outputs();
    end
  end

  task automatic print_counts();
    $display("errors: %0d checks, %0d assertions, %0d timeouts",
             errors, dut0.assert0.fail_count, timeouts);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      timeouts = 1;
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      print_counts();
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic idle();
    write_wen      <= 1'b0;
    write_instr_en <= '0;
    read_clk_en    <= 1'b0;
    read_instr_en  <= '0;
    except         <= 1'b0;
  endtask

  task automatic drive_write(input logic thread, input int n);
    instr_t [`IQ_WRITE_LANES-1:0] wi;
    other_t [`IQ_WRITE_LANES-1:0] wo;
    for (int k = 0; k < `IQ_WRITE_LANES; k++) begin
      wi[k] = $random(seed);
      wo[k] = $random(seed);
    end
    write_wen      <= (n > 0);
    write_thread   <= thread;
    write_instr_en <= wlanes_t'((5'd1 << n) - 5'd1);
    write_instr    <= wi;
    write_other    <= wo;
  endtask

  task automatic drive_read(input logic en, input int n);
    read_clk_en   <= en;
    read_instr_en <= rlanes_t'((4'd1 << n) - 4'd1);
  endtask

  task automatic random_cycle(input logic mix);
    int avail;
    tick();
    drive_write(mix ? rand_below(2) : 0, rand_below(5));
    // rd_thread_m is the thread consumed in the coming cycle
    avail = mq[rd_thread_m].size();
    if (avail > `IQ_READ_LANES) begin
      avail = `IQ_READ_LANES;
    end
    drive_read(rand_below(2), rand_below(avail + 1));
    read_thread <= mix ? rand_below(2) : 0;
    if (mix && (rand_below(16) == 0)) begin
      except        <= 1'b1;
      except_thread <= rand_below(2);
    end else begin
      except <= 1'b0;
    end
  endtask

  task automatic drain(input logic thread);
    int n;
    do begin
      tick();
      idle();
      read_thread <= thread;
      n = (rd_thread_m == thread) ? mq[thread].size() : 0;
      if (n > `IQ_READ_LANES) begin
        n = `IQ_READ_LANES;
      end
      drive_read(1'b1, n);
    end while ((rd_thread_m != thread) || (mq[thread].size() != 0));
  endtask

  initial begin
    seed           = 99;
    clk            = 1'b0;
    rst            = 1'b1;
    write_wen      = 1'b0;
    write_thread   = 1'b0;
    write_instr_en = '0;
    write_instr    = '0;
    write_other    = '0;
    read_thread    = 1'b0;
    read_clk_en    = 1'b0;
    read_instr_en  = '0;
    except         = 1'b0;
    except_thread  = 1'b0;
    repeat (5) tick();
    rst <= 1'b0;

    // empty queues right after reset
    repeat (4) begin
      tick();
      idle();
    end

    repeat (150) random_cycle(1'b0);
    repeat (200) random_cycle(1'b1);
    drain(1'b0);
    drain(1'b1);

    // fill thread 0 past the stall level
    stall_seen = 1'b0;
    repeat (8) begin
      tick();
      idle();
      read_thread <= 1'b0;
      drive_write(1'b0, 4);
    end
    tick();
    idle();
    assert (stall_seen) else begin
      errors++;
      $display("stall never rose while thread 0 was being filled");
    end
    drain(1'b0);

    // load both threads then flush thread 1
    for (int i = 0; i < 4; i++) begin
      tick();
      idle();
      drive_write(i / 2, 3);
    end
    tick();
    idle();
    read_thread <= 1'b1;
    tick();
    idle();
    except        <= 1'b1;
    except_thread <= 1'b1;
    tick();
    idle();
    @(negedge clk);
    assert (read_avail == '0) else report_mismatch("read_avail", 0, read_avail);
    drain(1'b1);
    drain(1'b0);
    tick();
    idle();
    repeat (2) tick();

    print_counts();
    if ((errors == 0) && (dut0.assert0.fail_count == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- iq_top.f
+incdir+include
design/iq_pkg.sv
design/iq_write_ctrl.sv
design/iq_storage.sv
design/iq_occupancy.sv
design/iq_read_ctrl.sv
design/iq_top.sv
tests/iq_assertions.sv
tests/tb_iq_top.sv
